//--- logic/axi_pkg.sv
package axi_pkg;

    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int id_w   = 4;

    // Response codes.
    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    // Read address channel.
    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [id_w-1:0]   id;
        logic [7:0]        len;   // Beats minus one.
        logic [2:0]        size;
        logic [1:0]        burst;
    } axi_ar_t;

    // Write address carries the same fields as a read address.
    typedef axi_ar_t axi_aw_t;

    typedef struct packed {
        logic [data_w-1:0]   data;
        logic [data_w/8-1:0] strb;
        logic                last;
    } axi_w_t;

    typedef struct packed {
        logic [data_w-1:0] data;
        logic [1:0]        resp;
        logic              last;
        logic [id_w-1:0]   id;
    } axi_r_t;

    typedef struct packed {
        logic [1:0]      resp;
        logic [id_w-1:0] id;
    } axi_b_t;

    // Bus owner.
    typedef enum logic [1:0] {
        arb_idle,
        arb_ifu,
        arb_lsu
    } arb_state_t;

endpackage

//--- logic/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter #(
    parameter logic [axi_pkg::addr_w-1:0] clint_base = 32'h0200_0000
) (
    input  logic             clk,
    input  logic             rst,

    input  axi_pkg::axi_ar_t ifu_ar,
    input  logic             ifu_ar_valid,
    output logic             ifu_ar_ready,
    output axi_pkg::axi_r_t  ifu_r,
    output logic             ifu_r_valid,
    input  logic             ifu_r_ready,

    input  axi_pkg::axi_ar_t lsu_ar,
    input  logic             lsu_ar_valid,
    output logic             lsu_ar_ready,
    input  axi_pkg::axi_aw_t lsu_aw,
    input  logic             lsu_aw_valid,
    output logic             lsu_aw_ready,
    input  axi_pkg::axi_w_t  lsu_w,
    input  logic             lsu_w_valid,
    output logic             lsu_w_ready,
    output axi_pkg::axi_b_t  lsu_b,
    output logic             lsu_b_valid,
    input  logic             lsu_b_ready,
    output axi_pkg::axi_r_t  lsu_r,
    output logic             lsu_r_valid,
    input  logic             lsu_r_ready,

    output axi_pkg::axi_ar_t ext_ar,
    output logic             ext_ar_valid,
    input  logic             ext_ar_ready,
    output axi_pkg::axi_aw_t ext_aw,
    output logic             ext_aw_valid,
    input  logic             ext_aw_ready,
    output axi_pkg::axi_w_t  ext_w,
    output logic             ext_w_valid,
    input  logic             ext_w_ready,
    input  axi_pkg::axi_b_t  ext_b,
    input  logic             ext_b_valid,
    output logic             ext_b_ready,
    input  axi_pkg::axi_r_t  ext_r,
    input  logic             ext_r_valid,
    output logic             ext_r_ready,

    output axi_pkg::axi_ar_t clint_ar,
    output logic             clint_ar_valid,
    input  logic             clint_ar_ready,
    input  axi_pkg::axi_r_t  clint_r,
    input  logic             clint_r_valid,
    output logic             clint_r_ready
);
    import axi_pkg::*;

    arb_state_t state;
    arb_state_t state_next;
    logic       to_clint;      // LSU read routed to the CLINT.
    logic       lsu_ar_is_clint;
    logic       ifu_done;
    logic       lsu_done;

    assign lsu_ar_is_clint = (lsu_ar.addr == clint_base) ||
                             (lsu_ar.addr == clint_base + addr_w'(4));

    // Readies below are zero unless the owner is routed there.
    assign ifu_done = ext_r_valid && ext_r_ready && ext_r.last;
    assign lsu_done = to_clint ? (clint_r_valid && clint_r_ready && clint_r.last) :
                      ((ext_r_valid && ext_r_ready && ext_r.last) ||
                       (ext_b_valid && ext_b_ready));

    always_comb begin
        state_next = state;
        case (state)
            arb_idle: begin
                if (lsu_ar_valid || lsu_aw_valid) begin
                    state_next = arb_lsu;  // LSU wins a tie.
                end else if (ifu_ar_valid) begin
                    state_next = arb_ifu;
                end
            end
            arb_ifu: if (ifu_done) state_next = arb_idle;
            arb_lsu: if (lsu_done) state_next = arb_idle;
            default: state_next = arb_idle;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= arb_idle;
            to_clint <= 1'b0;
        end else begin
            state <= state_next;
            if (state == arb_idle && state_next == arb_lsu) begin
                to_clint <= lsu_ar_valid && lsu_ar_is_clint;
            end
        end
    end

    // Payloads follow the owner, only the handshakes are gated.
    assign ext_ar   = (state == arb_ifu) ? ifu_ar : lsu_ar;
    assign ext_aw   = lsu_aw;
    assign ext_w    = lsu_w;
    assign clint_ar = lsu_ar;
    assign ifu_r    = ext_r;
    assign lsu_r    = to_clint ? clint_r : ext_r;
    assign lsu_b    = ext_b;

    always_comb begin
        ifu_ar_ready   = 1'b0;
        ifu_r_valid    = 1'b0;
        lsu_ar_ready   = 1'b0;
        lsu_aw_ready   = 1'b0;
        lsu_w_ready    = 1'b0;
        lsu_b_valid    = 1'b0;
        lsu_r_valid    = 1'b0;
        ext_ar_valid   = 1'b0;
        ext_aw_valid   = 1'b0;
        ext_w_valid    = 1'b0;
        ext_b_ready    = 1'b0;
        ext_r_ready    = 1'b0;
        clint_ar_valid = 1'b0;
        clint_r_ready  = 1'b0;
        case (state)
            arb_ifu: begin
                ext_ar_valid = ifu_ar_valid;
                ifu_ar_ready = ext_ar_ready;
                ifu_r_valid  = ext_r_valid;
                ext_r_ready  = ifu_r_ready;
            end
            arb_lsu: begin
                if (to_clint) begin
                    clint_ar_valid = lsu_ar_valid;
                    lsu_ar_ready   = clint_ar_ready;
                    lsu_r_valid    = clint_r_valid;
                    clint_r_ready  = lsu_r_ready;
                end else begin
                    ext_ar_valid = lsu_ar_valid;
                    lsu_ar_ready = ext_ar_ready;
                    lsu_r_valid  = ext_r_valid;
                    ext_r_ready  = lsu_r_ready;
                    ext_aw_valid = lsu_aw_valid;
                    lsu_aw_ready = ext_aw_ready;
                    ext_w_valid  = lsu_w_valid;
                    lsu_w_ready  = ext_w_ready;
                    lsu_b_valid  = ext_b_valid;
                    ext_b_ready  = lsu_b_ready;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

//--- logic/clint_timer.sv
`timescale 1ns/1ps

module clint_timer (
    input  logic             clk,
    input  logic             rst,
    input  axi_pkg::axi_ar_t ar,
    input  logic             ar_valid,
    output logic             ar_ready,
    output axi_pkg::axi_r_t  r,
    output logic             r_valid,
    input  logic             r_ready
);
    import axi_pkg::*;

    logic [63:0]       mtime;
    logic [data_w-1:0] r_data;
    logic [id_w-1:0]   r_id;
    logic              ar_fire;

    // One response in flight at most.
    assign ar_ready = !r_valid;
    assign ar_fire  = ar_valid && ar_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mtime <= 64'd0;
        end else begin
            mtime <= mtime + 64'd1;  // Free running.
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            r_valid <= 1'b0;
        end else if (ar_fire) begin
            r_valid <= 1'b1;
        end else if (r_ready) begin
            r_valid <= 1'b0;
        end
    end

    // Addr bit 2 picks the upper word.
    always_ff @(posedge clk) begin
        if (ar_fire) begin
            r_data <= ar.addr[2] ? mtime[63:32] : mtime[31:0];
            r_id   <= ar.id;
        end
    end

    // Single beat, always okay.
    assign r = '{
        data: r_data,
        resp: resp_okay,
        last: 1'b1,
        id:   r_id
    };

endmodule

//--- logic/mem_subsystem.sv
`timescale 1ns/1ps

module mem_subsystem #(
    parameter logic [axi_pkg::addr_w-1:0] clint_base = 32'h0200_0000
) (
    input  logic             clk,
    input  logic             rst,

    input  axi_pkg::axi_ar_t ifu_ar,
    input  logic             ifu_ar_valid,
    output logic             ifu_ar_ready,
    output axi_pkg::axi_r_t  ifu_r,
    output logic             ifu_r_valid,
    input  logic             ifu_r_ready,

    input  axi_pkg::axi_ar_t lsu_ar,
    input  logic             lsu_ar_valid,
    output logic             lsu_ar_ready,
    input  axi_pkg::axi_aw_t lsu_aw,
    input  logic             lsu_aw_valid,
    output logic             lsu_aw_ready,
    input  axi_pkg::axi_w_t  lsu_w,
    input  logic             lsu_w_valid,
    output logic             lsu_w_ready,
    output axi_pkg::axi_b_t  lsu_b,
    output logic             lsu_b_valid,
    input  logic             lsu_b_ready,
    output axi_pkg::axi_r_t  lsu_r,
    output logic             lsu_r_valid,
    input  logic             lsu_r_ready,

    output axi_pkg::axi_ar_t ext_ar,
    output logic             ext_ar_valid,
    input  logic             ext_ar_ready,
    output axi_pkg::axi_aw_t ext_aw,
    output logic             ext_aw_valid,
    input  logic             ext_aw_ready,
    output axi_pkg::axi_w_t  ext_w,
    output logic             ext_w_valid,
    input  logic             ext_w_ready,
    input  axi_pkg::axi_b_t  ext_b,
    input  logic             ext_b_valid,
    output logic             ext_b_ready,
    input  axi_pkg::axi_r_t  ext_r,
    input  logic             ext_r_valid,
    output logic             ext_r_ready
);
    import axi_pkg::*;

    // Link from the arbiter to the timer.
    axi_ar_t clint_ar;
    logic    clint_ar_valid;
    logic    clint_ar_ready;
    axi_r_t  clint_r;
    logic    clint_r_valid;
    logic    clint_r_ready;

    bus_arbiter #(
        .clint_base(clint_base)
    ) bus_arbiter_i (
        .*
    );

    clint_timer clint_timer_i (
        .clk      (clk),
        .rst      (rst),
        .ar       (clint_ar),
        .ar_valid (clint_ar_valid),
        .ar_ready (clint_ar_ready),
        .r        (clint_r),
        .r_valid  (clint_r_valid),
        .r_ready  (clint_r_ready)
    );

endmodule

//--- tests/axi_mem_model.sv
`timescale 1ns/1ps

module axi_mem_model (
    input  logic             clk,
    input  logic             rst,
    input  logic             stall_en,  // Random ready and valid stalls.
    input  axi_pkg::axi_ar_t ar,
    input  logic             ar_valid,
    output logic             ar_ready,
    input  axi_pkg::axi_aw_t aw,
    input  logic             aw_valid,
    output logic             aw_ready,
    input  axi_pkg::axi_w_t  w,
    input  logic             w_valid,
    output logic             w_ready,
    output axi_pkg::axi_b_t  b,
    output logic             b_valid,
    input  logic             b_ready,
    output axi_pkg::axi_r_t  r,
    output logic             r_valid,
    input  logic             r_ready
);
    import axi_pkg::*;

    logic [data_w-1:0] mem [0:1023];
    logic [9:0]        rd_idx;
    logic [7:0]        rd_left;
    logic [id_w-1:0]   rd_id;
    logic              rd_busy;
    logic [9:0]        wr_idx;
    logic              wr_busy;
    int                seed = 37;

    // Moves on three cycles out of four when stalls are on.
    function automatic logic go();
        return !stall_en || ({$random(seed)} % 4 != 0);
    endfunction

    initial begin
        for (int i = 0; i < 1024; i++) begin
            mem[i] = 32'(i) * 32'h0101_0001;
        end
    end

    // Read side, incrementing bursts.
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            ar_ready <= 1'b0;
            r_valid  <= 1'b0;
            rd_busy  <= 1'b0;
        end else if (!rd_busy) begin
            if (ar_valid && ar_ready) begin
                ar_ready <= 1'b0;
                rd_busy  <= 1'b1;
                rd_idx   <= ar.addr[11:2];
                rd_left  <= ar.len;
                rd_id    <= ar.id;
            end else begin
                ar_ready <= go();
            end
        end else if (!r_valid || r_ready) begin
            if (r_valid && r.last) begin
                r_valid <= 1'b0;  // Burst done.
                rd_busy <= 1'b0;
            end else if (go()) begin
                r_valid <= 1'b1;
                r       <= '{data: mem[rd_idx], resp: resp_okay,
                             last: rd_left == 8'd0, id: rd_id};
                rd_idx  <= rd_idx + 10'd1;
                rd_left <= rd_left - 8'd1;
            end else begin
                r_valid <= 1'b0;
            end
        end
    end

    // Write side, byte strobes honoured.
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            aw_ready <= 1'b0;
            w_ready  <= 1'b0;
            b_valid  <= 1'b0;
            wr_busy  <= 1'b0;
        end else if (!wr_busy) begin
            if (aw_valid && aw_ready) begin
                aw_ready <= 1'b0;
                wr_busy  <= 1'b1;
                wr_idx   <= aw.addr[11:2];
                b.id     <= aw.id;
            end else begin
                aw_ready <= go();
            end
        end else if (b_valid) begin
            if (b_ready) begin
                b_valid <= 1'b0;
                wr_busy <= 1'b0;
            end
        end else if (w_valid && w_ready) begin
            for (int k = 0; k < 4; k++) begin
                if (w.strb[k]) begin
                    mem[wr_idx][8*k +: 8] <= w.data[8*k +: 8];
                end
            end
            wr_idx  <= wr_idx + 10'd1;
            w_ready <= !w.last && go();
            b_valid <= w.last;
            b.resp  <= resp_okay;
        end else begin
            w_ready <= go();
        end
    end

endmodule

//--- tests/mem_subsystem_properties.sv
`timescale 1ns/1ps

module mem_subsystem_properties (
    input logic                clk,
    input logic                rst,
    input axi_pkg::arb_state_t state,
    input logic                ext_ar_valid,
    input logic                ext_aw_valid,
    input logic                ext_w_valid,
    input logic                clint_ar_valid,
    input logic                ifu_ar_ready,
    input logic                ifu_r_valid,
    input logic                lsu_r_valid,
    input logic                lsu_b_valid
);
    import axi_pkg::*;

    int assert_fails = 0;

    // A read address goes to one slave only.
    ar_one_slave: assert property (@(posedge clk) disable iff (rst)
        !(ext_ar_valid && clint_ar_valid))
    else begin
        $error("ext_ar_valid and clint_ar_valid high together");
        assert_fails++;
    end

    ifu_quiet: assert property (@(posedge clk) disable iff (rst)
        (state == arb_lsu) |-> !(ifu_ar_ready || ifu_r_valid))
    else begin
        $error("IFU channel active while the LSU owns the bus");
        assert_fails++;
    end

    reset_quiet: assert property (@(posedge clk)
        rst |-> !(ext_ar_valid || ext_aw_valid || ext_w_valid || clint_ar_valid ||
                  ifu_r_valid || lsu_r_valid || lsu_b_valid))
    else begin
        $error("valid high during reset");
        assert_fails++;
    end

endmodule

bind bus_arbiter mem_subsystem_properties properties_i (.*);

//--- tests/tb_mem_subsystem.sv
`timescale 1ns/1ps

module tb_mem_subsystem;
    import axi_pkg::*;

    localparam logic [addr_w-1:0] clint_base = 32'h0200_0000;
    localparam int n_tests = 5;

    logic    clk;
    logic    rst;
    axi_ar_t ifu_ar;
    logic    ifu_ar_valid, ifu_ar_ready;
    axi_r_t  ifu_r;
    logic    ifu_r_valid, ifu_r_ready;
    axi_ar_t lsu_ar;
    logic    lsu_ar_valid, lsu_ar_ready;
    axi_aw_t lsu_aw;
    logic    lsu_aw_valid, lsu_aw_ready;
    axi_w_t  lsu_w;
    logic    lsu_w_valid, lsu_w_ready;
    axi_b_t  lsu_b;
    logic    lsu_b_valid, lsu_b_ready;
    axi_r_t  lsu_r;
    logic    lsu_r_valid, lsu_r_ready;
    axi_ar_t ext_ar;
    logic    ext_ar_valid, ext_ar_ready;
    axi_aw_t ext_aw;
    logic    ext_aw_valid, ext_aw_ready;
    axi_w_t  ext_w;
    logic    ext_w_valid, ext_w_ready;
    axi_b_t  ext_b;
    logic    ext_b_valid, ext_b_ready;
    axi_r_t  ext_r;
    logic    ext_r_valid, ext_r_ready;

    logic       stall_en;
    logic       r_gaps;  // Random r_ready gaps from the masters.
    int         seed;
    int         errors;
    int         cycle;
    int         ext_ar_cycles;
    int         ifu_ar_cyc, ifu_end_cyc, lsu_ar_cyc, lsu_aw_start, lsu_aw_cyc, lsu_end_cyc;
    axi_b_t     lsu_b_got;
    axi_r_t     ifu_got[$];
    axi_r_t     lsu_got[$];

    mem_subsystem #(.clint_base(clint_base)) mem_subsystem_i (.*);

    axi_mem_model mem_model_i (
        .clk, .rst, .stall_en,
        .ar(ext_ar), .ar_valid(ext_ar_valid), .ar_ready(ext_ar_ready),
        .aw(ext_aw), .aw_valid(ext_aw_valid), .aw_ready(ext_aw_ready),
        .w(ext_w), .w_valid(ext_w_valid), .w_ready(ext_w_ready),
        .b(ext_b), .b_valid(ext_b_valid), .b_ready(ext_b_ready),
        .r(ext_r), .r_valid(ext_r_valid), .r_ready(ext_r_ready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            cycle         <= 0;
            ext_ar_cycles <= 0;
        end else begin
            cycle <= cycle + 1;
            if (ext_ar_valid) ext_ar_cycles <= ext_ar_cycles + 1;
        end
    end

    // Ends a run that stalls.
    initial begin
        repeat (200 * n_tests) @(posedge clk);
        $display("Timeout: tests still running after %0d cycles", 200 * n_tests);
        $display("sim failed");
        $finish;
    end

    function automatic logic [31:0] init_word(input int idx);
        return 32'(idx) * 32'h0101_0001;
    endfunction

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s: got %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_burst(input axi_r_t beats[$], input int first, input int len,
                               input logic [3:0] id, input string who);
        check(32'(beats.size()), 32'(len + 1), {who, " beat count"});
        foreach (beats[k]) begin
            check(beats[k].data, init_word(first + k), {who, " data"});
            check(32'(beats[k].last), 32'(k == len), {who, " last"});
            check(32'(beats[k].id), 32'(id), {who, " id"});
            check(32'(beats[k].resp), 32'(resp_okay), {who, " resp"});
        end
    endtask

    // Samples 1 ns after the falling edge, so a high ready means a transfer next edge.
    task automatic ifu_read(input logic [31:0] addr, input logic [7:0] len,
                            input logic [3:0] id);
        logic done;
        ifu_got.delete();
        @(negedge clk);
        ifu_ar = '{addr: addr, id: id, len: len, size: 3'd2, burst: 2'b01};
        ifu_ar_valid = 1'b1;
        #1;
        while (!ifu_ar_ready) begin
            @(negedge clk);
            #1;
        end
        ifu_ar_cyc = cycle;
        @(negedge clk);
        ifu_ar_valid = 1'b0;
        done = 1'b0;
        while (!done) begin
            ifu_r_ready = !r_gaps || ({$random(seed)} % 3 != 0);
            #1;
            if (ifu_r_valid && ifu_r_ready) begin
                ifu_got.push_back(ifu_r);
                done = ifu_r.last;
            end
            @(negedge clk);
        end
        ifu_end_cyc = cycle;
        ifu_r_ready = 1'b0;
    endtask

    task automatic lsu_read(input logic [31:0] addr, input logic [7:0] len,
                            input logic [3:0] id);
        logic done;
        lsu_got.delete();
        @(negedge clk);
        lsu_ar = '{addr: addr, id: id, len: len, size: 3'd2, burst: 2'b01};
        lsu_ar_valid = 1'b1;
        #1;
        while (!lsu_ar_ready) begin
            @(negedge clk);
            #1;
        end
        lsu_ar_cyc = cycle;
        @(negedge clk);
        lsu_ar_valid = 1'b0;
        done = 1'b0;
        while (!done) begin
            lsu_r_ready = !r_gaps || ({$random(seed)} % 3 != 0);
            #1;
            if (lsu_r_valid && lsu_r_ready) begin
                lsu_got.push_back(lsu_r);
                done = lsu_r.last;
            end
            @(negedge clk);
        end
        lsu_end_cyc = cycle;
        lsu_r_ready = 1'b0;
    endtask

    task automatic lsu_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input logic [3:0] id);
        logic aw_done;
        logic w_done;
        logic b_done;
        @(negedge clk);
        lsu_aw = '{addr: addr, id: id, len: 8'd0, size: 3'd2, burst: 2'b01};
        lsu_w  = '{data: data, strb: strb, last: 1'b1};
        lsu_aw_valid = 1'b1;
        lsu_w_valid  = 1'b1;
        lsu_b_ready  = 1'b1;
        lsu_aw_start = cycle;
        aw_done = 1'b0;
        w_done  = 1'b0;
        b_done  = 1'b0;
        while (!b_done) begin
            #1;
            if (lsu_aw_valid && lsu_aw_ready) begin
                aw_done    = 1'b1;
                lsu_aw_cyc = cycle;
            end
            if (lsu_w_valid && lsu_w_ready) w_done = 1'b1;
            if (lsu_b_valid) begin
                lsu_b_got = lsu_b;
                b_done    = 1'b1;
            end
            @(negedge clk);
            if (aw_done) lsu_aw_valid = 1'b0;
            if (w_done) lsu_w_valid = 1'b0;
        end
        lsu_b_ready = 1'b0;
    endtask

    task automatic burst_read_test();
        ifu_read(32'h0000_0100, 8'd3, 4'h5);
        check_burst(ifu_got, 'h40, 3, 4'h5, "ifu burst");
    endtask

    task automatic strobe_write_test();
        logic [31:0] exp;
        exp = (init_word('h80) & 32'hff00_ff00) | (32'hdead_beef & 32'h00ff_00ff);
        lsu_write(32'h0000_0200, 32'hdead_beef, 4'b0101, 4'h3);
        // Idle slave is ready, so the grant cycle is the handshake cycle.
        check(32'(lsu_aw_cyc - lsu_aw_start), 32'd1, "write grant latency");
        check(32'(lsu_b_got.resp), 32'(resp_okay), "write response");
        check(32'(lsu_b_got.id), 32'h3, "write response id");
        lsu_read(32'h0000_0200, 8'd0, 4'h3);
        check(lsu_got[0].data, exp, "strobed word");
    endtask

    task automatic clint_read_test();
        logic [31:0] first;
        int          first_cyc;
        int          ext_before;
        ext_before = ext_ar_cycles;
        lsu_read(clint_base, 8'd0, 4'h7);
        first     = lsu_got[0].data;
        first_cyc = lsu_ar_cyc;
        check(32'(lsu_got[0].id), 32'h7, "clint id");
        check(32'(lsu_got[0].resp), 32'(resp_okay), "clint resp");
        lsu_read(clint_base, 8'd0, 4'h7);
        check(lsu_got[0].data - first, 32'(lsu_ar_cyc - first_cyc), "mtime step");
        lsu_read(clint_base + 32'd4, 8'd0, 4'h7);
        check(lsu_got[0].data, 32'd0, "mtime upper half");
        check(32'(ext_ar_cycles - ext_before), 32'd0, "ext_ar_valid during clint reads");
    endtask

    task automatic tie_test();
        fork
            ifu_read(32'h0000_0300, 8'd1, 4'h1);
            lsu_read(32'h0000_0600, 8'd1, 4'h2);
        join
        check_burst(ifu_got, 'hc0, 1, 4'h1, "tie ifu");
        check_burst(lsu_got, 'h180, 1, 4'h2, "tie lsu");
        check(32'(lsu_ar_cyc < ifu_ar_cyc), 32'd1, "lsu granted before ifu");
        check(32'(lsu_end_cyc < ifu_end_cyc), 32'd1, "lsu finishes before ifu");
    endtask

    task automatic stall_test();
        @(negedge clk);
        stall_en = 1'b1;
        r_gaps   = 1'b1;
        ifu_read(32'h0000_0800, 8'd7, 4'h9);
        check_burst(ifu_got, 'h200, 7, 4'h9, "stalled ifu");
        lsu_read(32'h0000_0400, 8'd3, 4'h4);
        check_burst(lsu_got, 'h100, 3, 4'h4, "stalled lsu");
        stall_en = 1'b0;
        r_gaps   = 1'b0;
    endtask

    initial begin
        seed         = 37;
        errors       = 0;
        rst          = 1'b1;
        stall_en     = 1'b0;
        r_gaps       = 1'b0;
        ifu_ar       = '0;
        ifu_ar_valid = 1'b0;
        ifu_r_ready  = 1'b0;
        lsu_ar       = '0;
        lsu_ar_valid = 1'b0;
        lsu_aw       = '0;
        lsu_aw_valid = 1'b0;
        lsu_w        = '0;
        lsu_w_valid  = 1'b0;
        lsu_b_ready  = 1'b0;
        lsu_r_ready  = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        burst_read_test();
        strobe_write_test();
        clint_read_test();
        tie_test();
        stall_test();
        repeat (4) @(negedge clk);
        $display("Summary: %0d check errors, %0d assertion failures", errors,
                 mem_subsystem_i.bus_arbiter_i.properties_i.assert_fails);
        if (errors == 0 && mem_subsystem_i.bus_arbiter_i.properties_i.assert_fails == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- sim.f
logic/axi_pkg.sv
logic/bus_arbiter.sv
logic/clint_timer.sv
logic/mem_subsystem.sv
tests/axi_mem_model.sv
tests/mem_subsystem_properties.sv
tests/tb_mem_subsystem.sv

//--- Makefile
# Build with Verilator, run into sim.log and scan the log for the fail message.

sim:
	verilator --binary --timing --assert --top-module tb_mem_subsystem -f sim.f
	./obj_dir/Vtb_mem_subsystem +verilator+error+limit+100 > sim.log 2>&1 || \
		echo "sim failed" >> sim.log
	cat sim.log
	@if grep -q "sim failed" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
